// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // cache geometry.
  localparam int line_words = 4;
  localparam int cache_lines = 16;
  localparam int offset_bits = $clog2(line_words);
  localparam int index_bits = $clog2(cache_lines);
  localparam int tag_bits = xlen - index_bits - offset_bits - 2;

  typedef logic [xlen-1:0] word_t;
  typedef logic [offset_bits-1:0] offset_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [tag_bits-1:0] tag_t;

  typedef enum logic [3:0] {
    kind_branch,
    kind_jal,
    kind_jalr,
    kind_load,
    kind_store,
    kind_alu_imm,
    kind_alu_reg,
    kind_lui,
    kind_auipc,
    kind_system,
    kind_other
  } inst_kind_t;

  // major opcodes, inst[6:2].
  localparam logic [4:0] op_load = 5'b00000;
  localparam logic [4:0] op_alu_imm = 5'b00100;
  localparam logic [4:0] op_auipc = 5'b00101;
  localparam logic [4:0] op_store = 5'b01000;
  localparam logic [4:0] op_alu_reg = 5'b01100;
  localparam logic [4:0] op_lui = 5'b01101;
  localparam logic [4:0] op_branch = 5'b11000;
  localparam logic [4:0] op_jalr = 5'b11001;
  localparam logic [4:0] op_jal = 5'b11011;
  localparam logic [4:0] op_system = 5'b11100;

endpackage

`default_nettype wire

// File: hdl/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_if import fetch_pkg::*; ();

  logic valid;
  logic ready;
  word_t pc;
  word_t inst;

  modport source (
    output valid,
    output pc,
    output inst,
    input ready
  );

  modport sink (
    input valid,
    input pc,
    input inst,
    output ready
  );

endinterface

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import fetch_pkg::*; (
  input wire logic clock,
  input wire logic reset,
  input wire logic fencei,
  input wire word_t fetch_pc,
  input wire logic mem_rvalid,
  input wire word_t mem_rdata,
  output logic hit,
  output word_t hit_inst,
  output logic mem_req,
  output word_t mem_addr
);

  typedef enum logic {
    st_idle,
    st_refill
  } state_t;

  state_t state;

  tag_t tag_mem [cache_lines];
  word_t data_mem [cache_lines][line_words];
  logic [cache_lines-1:0] valid_bits;

  word_t refill_addr;
  offset_t beat_cnt;
  logic fence_seen;

  offset_t pc_offset;
  index_t pc_index;
  tag_t pc_tag;
  index_t refill_index;
  tag_t refill_tag;
  logic lookup_hit;
  logic last_beat;

  // address split above the byte offset.
  assign pc_offset = fetch_pc[offset_bits+1:2];
  assign pc_index = fetch_pc[index_bits+offset_bits+1:offset_bits+2];
  assign pc_tag = fetch_pc[xlen-1:xlen-tag_bits];

  assign refill_index = refill_addr[index_bits+offset_bits+1:offset_bits+2];
  assign refill_tag = refill_addr[xlen-1:xlen-tag_bits];

  assign lookup_hit = valid_bits[pc_index] && (tag_mem[pc_index] == pc_tag);
  assign last_beat = (beat_cnt == offset_t'(line_words - 1));

  // the line under refill never reports a hit.
  assign hit = (state == st_idle) && lookup_hit;
  assign hit_inst = data_mem[pc_index][pc_offset];
  assign mem_addr = refill_addr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      mem_req <= 1'b0;
      beat_cnt <= '0;
      fence_seen <= 1'b0;
      valid_bits <= '0;
    end else begin
      mem_req <= 1'b0;
      case (state)
        st_idle: begin
          if (!lookup_hit) begin
            state <= st_refill;
            mem_req <= 1'b1;
            beat_cnt <= '0;
            fence_seen <= 1'b0;
          end
        end
        st_refill: begin
          if (mem_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= st_idle;
              // a fence during the refill makes the line stale.
              if (!fence_seen && !fencei) begin
                valid_bits[refill_index] <= 1'b1;
              end
            end
          end
        end
        default: state <= st_idle;
      endcase
      if (fencei) begin
        valid_bits <= '0;
        if (state == st_refill) begin
          fence_seen <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && !lookup_hit) begin
      refill_addr <= {fetch_pc[xlen-1:offset_bits+2], {(offset_bits + 2){1'b0}}};
    end
    if (state == st_refill && mem_rvalid) begin
      data_mem[refill_index][beat_cnt] <= mem_rdata;
      if (last_beat) begin
        tag_mem[refill_index] <= refill_tag;
      end
    end
  end

  // memory beats only answer an outstanding request.
  beat_in_refill: assert property (
    @(posedge clock) disable iff (reset)
    mem_rvalid |-> (state == st_refill)
  );

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import fetch_pkg::*; (
  input wire logic clock,
  input wire logic reset,
  input wire logic redirect,
  input wire word_t redirect_pc,
  input wire logic hit,
  input wire word_t hit_inst,
  output word_t fetch_pc,
  fetch_if.source out
);

  typedef enum logic {
    st_wait,
    st_hold
  } state_t;

  state_t state, state_next;

  logic out_valid_r, out_valid_next;
  word_t out_pc_next, out_inst_next;
  word_t fetch_pc_next;
  logic pend_r, pend_next;
  word_t pend_pc, pend_pc_next;

  word_t imm_b;
  logic predict_taken;
  word_t fetch_pc_pred;

  // backward conditional branches are taken.
  assign imm_b = {{20{hit_inst[31]}}, hit_inst[7], hit_inst[30:25], hit_inst[11:8], 1'b0};
  assign predict_taken = (hit_inst[6:2] == op_branch) && hit_inst[31];
  assign fetch_pc_pred = fetch_pc + (predict_taken ? imm_b : word_t'(4));

  always_comb begin
    state_next = state;
    out_valid_next = out_valid_r;
    out_pc_next = out.pc;
    out_inst_next = out.inst;
    fetch_pc_next = fetch_pc;
    pend_next = pend_r;
    pend_pc_next = pend_pc;

    if (state == st_wait) begin
      if (hit) begin
        if (redirect || pend_r) begin
          pend_next = 1'b0;
          out_valid_next = 1'b0;
          fetch_pc_next = redirect ? redirect_pc : pend_pc;
        end else if (!out_valid_r || out.ready) begin
          out_valid_next = 1'b1;
          out_pc_next = fetch_pc;
          out_inst_next = hit_inst;
          fetch_pc_next = fetch_pc_pred;
        end else begin
          state_next = st_hold;
        end
      end else begin
        // remember the target until the refill ends.
        if (redirect) begin
          pend_next = 1'b1;
          pend_pc_next = redirect_pc;
        end
        if (out.ready || redirect) begin
          out_valid_next = 1'b0;
        end
      end
    end else begin
      if (redirect) begin
        state_next = st_wait;
        out_valid_next = 1'b0;
        fetch_pc_next = redirect_pc;
      end else if (out.ready) begin
        state_next = st_wait;
        if (hit) begin
          out_valid_next = 1'b1;
          out_pc_next = fetch_pc;
          out_inst_next = hit_inst;
          fetch_pc_next = fetch_pc_pred;
        end else begin
          out_valid_next = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_wait;
      out_valid_r <= 1'b0;
      pend_r <= 1'b0;
      fetch_pc <= reset_pc;
    end else begin
      state <= state_next;
      out_valid_r <= out_valid_next;
      pend_r <= pend_next;
      fetch_pc <= fetch_pc_next;
    end
  end

  always_ff @(posedge clock) begin
    out.pc <= out_pc_next;
    out.inst <= out_inst_next;
    pend_pc <= pend_pc_next;
  end

  assign out.valid = out_valid_r && !redirect;

  // a stalled item stays put until taken or dropped by a redirect.
  hold_stable: assert property (
    @(posedge clock) disable iff (reset)
    (out.valid && !out.ready) |=>
      ((out.valid || redirect) && $stable(out.pc) && $stable(out.inst))
  );

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import fetch_pkg::*; (
  input wire logic clock,
  input wire logic reset,
  input wire logic redirect,
  input wire logic dec_ready,
  fetch_if.sink in,
  output logic dec_valid,
  output word_t dec_pc,
  output word_t dec_inst,
  output inst_kind_t dec_kind,
  output word_t dec_imm
);

  logic dec_valid_r;
  logic take;
  inst_kind_t kind;
  word_t imm;

  function automatic inst_kind_t classify(input word_t inst);
    case (inst[6:2])
      op_branch: return kind_branch;
      op_jal: return kind_jal;
      op_jalr: return kind_jalr;
      op_load: return kind_load;
      op_store: return kind_store;
      op_alu_imm: return kind_alu_imm;
      op_alu_reg: return kind_alu_reg;
      op_lui: return kind_lui;
      op_auipc: return kind_auipc;
      op_system: return kind_system;
      default: return kind_other;
    endcase
  endfunction

  // sign-extended immediate by instruction format.
  function automatic word_t form_imm(input word_t inst, input inst_kind_t k);
    case (k)
      kind_load, kind_alu_imm, kind_jalr, kind_system:
        return {{20{inst[31]}}, inst[31:20]};
      kind_store:
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
      kind_branch:
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      kind_lui, kind_auipc:
        return {inst[31:12], 12'b0};
      kind_jal:
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        return '0;
    endcase
  endfunction

  assign kind = classify(in.inst);
  assign imm = form_imm(in.inst, kind);

  assign in.ready = !dec_valid_r || dec_ready;
  assign take = in.valid && in.ready;
  assign dec_valid = dec_valid_r && !redirect;

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid_r <= 1'b0;
    end else if (redirect) begin
      dec_valid_r <= 1'b0;
    end else if (take) begin
      dec_valid_r <= 1'b1;
    end else if (dec_ready) begin
      dec_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      dec_pc <= in.pc;
      dec_inst <= in.inst;
      dec_kind <= kind;
      dec_imm <= imm;
    end
  end

  // nothing from the old path survives a redirect.
  flush_empty: assert property (
    @(posedge clock) disable iff (reset)
    redirect |=> !dec_valid
  );

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input wire logic clock,
  input wire logic reset,
  input wire logic redirect,
  input wire word_t redirect_pc,
  input wire logic fencei,
  input wire logic mem_rvalid,
  input wire word_t mem_rdata,
  input wire logic dec_ready,
  output logic mem_req,
  output word_t mem_addr,
  output logic dec_valid,
  output word_t dec_pc,
  output word_t dec_inst,
  output inst_kind_t dec_kind,
  output word_t dec_imm
);

  word_t fetch_pc;
  logic hit;
  word_t hit_inst;

  fetch_if fetch_bus ();

  icache icache_inst (
    .clock(clock),
    .reset(reset),
    .fencei(fencei),
    .fetch_pc(fetch_pc),
    .mem_rvalid(mem_rvalid),
    .mem_rdata(mem_rdata),
    .hit(hit),
    .hit_inst(hit_inst),
    .mem_req(mem_req),
    .mem_addr(mem_addr)
  );

  fetch_unit fetch_unit_inst (
    .clock(clock),
    .reset(reset),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .hit(hit),
    .hit_inst(hit_inst),
    .fetch_pc(fetch_pc),
    .out(fetch_bus.source)
  );

  decode_stage decode_stage_inst (
    .clock(clock),
    .reset(reset),
    .redirect(redirect),
    .dec_ready(dec_ready),
    .in(fetch_bus.sink),
    .dec_valid(dec_valid),
    .dec_pc(dec_pc),
    .dec_inst(dec_inst),
    .dec_kind(dec_kind),
    .dec_imm(dec_imm)
  );

endmodule

`default_nettype wire

// File: test/fetch_tb_model.svh
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

// reference class of an instruction from its 7-bit opcode.
function automatic inst_kind_t classify_inst(input word_t inst);
  case (inst[6:0])
    7'b1100011: return kind_branch;
    7'b1101111: return kind_jal;
    7'b1100111: return kind_jalr;
    7'b0000011: return kind_load;
    7'b0100011: return kind_store;
    7'b0010011: return kind_alu_imm;
    7'b0110011: return kind_alu_reg;
    7'b0110111: return kind_lui;
    7'b0010111: return kind_auipc;
    7'b1110011: return kind_system;
    default: return kind_other;
  endcase
endfunction

// reference immediate by format.
function automatic word_t decode_imm(input word_t inst);
  word_t imm;
  imm = '0;
  case (classify_inst(inst))
    kind_load, kind_alu_imm, kind_jalr, kind_system: begin
      imm = word_t'($signed(inst[31:20]));
    end
    kind_store: begin
      imm = word_t'($signed({inst[31:25], inst[11:7]}));
    end
    kind_branch: begin
      imm = word_t'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    end
    kind_lui, kind_auipc: begin
      imm = {inst[31:12], 12'h000};
    end
    kind_jal: begin
      imm = word_t'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
    end
    default: imm = '0;
  endcase
  return imm;
endfunction

// only backward conditional branches leave the straight line.
function automatic word_t next_fetch_pc(input word_t pc, input word_t inst);
  word_t offset;
  offset = decode_imm(inst);
  if (classify_inst(inst) == kind_branch && offset[31]) begin
    return pc + offset;
  end
  return pc + 32'd4;
endfunction

`endif

// File: test/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

  `include "fetch_tb_model.svh"

  localparam logic [31:0] seed = 32'h99a2_73ee;
  localparam int cycles_per_inst = 200;
  localparam int cycles_extra = 1000;

  logic clock = 1'b0;
  logic reset;
  logic redirect;
  word_t redirect_pc;
  logic fencei;
  logic mem_rvalid;
  word_t mem_rdata;
  logic dec_ready;
  logic mem_req;
  word_t mem_addr;
  logic dec_valid;
  word_t dec_pc;
  word_t dec_inst;
  inst_kind_t dec_kind;
  word_t dec_imm;

  word_t mem [word_t];
  byte ev_type [$];
  int ev_ord [$];
  word_t ev_addr [$];
  word_t ev_data [$];
  int total;
  bit loaded = 0;

  logic [31:0] rng = seed;
  int accepted = 0;
  int ev_idx = 0;
  word_t exp_pc = reset_pc;
  bit busy = 0;
  word_t req_addr;
  int beat;
  int gap;
  bit fence_check = 0;
  bit refill_seen = 0;
  word_t fence_line;

  fetch_top fetch_top_inst (
    .clock(clock),
    .reset(reset),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .fencei(fencei),
    .mem_rvalid(mem_rvalid),
    .mem_rdata(mem_rdata),
    .dec_ready(dec_ready),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .dec_valid(dec_valid),
    .dec_pc(dec_pc),
    .dec_inst(dec_inst),
    .dec_kind(dec_kind),
    .dec_imm(dec_imm)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // unlisted words become addi x0 with an address-derived immediate.
  function automatic word_t read_word(input word_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr[31:20] ^ addr[19:8] ^ addr[11:0], 20'h00013};
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic compare_kind(input string name, input inst_kind_t got, input inst_kind_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic load_input();
    int fd;
    int n;
    string line;
    string tok;
    int ord;
    word_t a;
    word_t d;
    fd = $fopen("test/fetch_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/fetch_input.txt");
      $display("=== FAIL ===");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s", tok);
      if (tok == "m") begin
        n = $sscanf(line, "%s %h %h", tok, a, d);
        mem[a] = d;
      end else if (tok == "n") begin
        n = $sscanf(line, "%s %d", tok, total);
      end else if (tok == "w") begin
        n = $sscanf(line, "%s %d %h %h", tok, ord, a, d);
        ev_type.push_back("w");
        ev_ord.push_back(ord);
        ev_addr.push_back(a);
        ev_data.push_back(d);
      end else begin
        n = $sscanf(line, "%s %d %h", tok, ord, a);
        ev_type.push_back(tok[0]);
        ev_ord.push_back(ord);
        ev_addr.push_back(a);
        ev_data.push_back('0);
      end
    end
    $fclose(fd);
  endtask

  // events fire once the tied number of items has been accepted.
  task automatic apply_events();
    while (ev_idx < ev_type.size() && ev_ord[ev_idx] == accepted) begin
      if (ev_type[ev_idx] == "w") begin
        mem[ev_addr[ev_idx]] = ev_data[ev_idx];
      end else begin
        redirect = 1'b1;
        redirect_pc = ev_addr[ev_idx];
        exp_pc = ev_addr[ev_idx];
        if (ev_type[ev_idx] == "f") begin
          fencei = 1'b1;
          fence_line = ev_addr[ev_idx] & ~32'hf;
          fence_check = 1;
          refill_seen = 0;
        end
      end
      ev_idx++;
    end
  endtask

  // four beats per request at random gaps.
  task automatic memory_step();
    if (mem_req) begin
      compare_bit("refill_outstanding", busy, 1'b0);
      busy = 1;
      req_addr = mem_addr;
      beat = 0;
      rng = xorshift(rng);
      gap = rng[1:0];
      if (fence_check && mem_addr == fence_line) refill_seen = 1;
    end
    mem_rvalid = 1'b0;
    if (busy) begin
      if (gap != 0) begin
        gap--;
      end else begin
        mem_rvalid = 1'b1;
        mem_rdata = read_word(req_addr + word_t'(4 * beat));
        beat++;
        rng = xorshift(rng);
        gap = rng[1:0];
        if (beat == line_words) busy = 0;
      end
    end
  endtask

  task automatic check_item();
    word_t exp_inst;
    exp_inst = read_word(exp_pc);
    compare_word("dec_pc", dec_pc, exp_pc);
    compare_word("dec_inst", dec_inst, exp_inst);
    compare_kind("dec_kind", dec_kind, classify_inst(exp_inst));
    compare_word("dec_imm", dec_imm, decode_imm(exp_inst));
    if (fence_check) begin
      compare_bit("refill_after_fencei", refill_seen, 1'b1);
      fence_check = 0;
    end
    exp_pc = next_fetch_pc(exp_pc, exp_inst);
    accepted++;
  endtask

  initial begin
    wait (loaded);
    repeat (cycles_per_inst * total + cycles_extra) @(posedge clock);
    $display("timeout after %0d of %0d accepted instructions", accepted, total);
    $display("=== FAIL ===");
    $fatal(1);
  end

  initial begin
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    fencei = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    dec_ready = 1'b0;
    load_input();
    loaded = 1;
    repeat (5) @(negedge clock);
    // nothing requested or offered out of reset.
    compare_bit("mem_req", mem_req, 1'b0);
    compare_bit("dec_valid", dec_valid, 1'b0);
    reset = 1'b0;
    while (accepted < total) begin
      @(negedge clock);
      redirect = 1'b0;
      fencei = 1'b0;
      apply_events();
      rng = xorshift(rng);
      dec_ready = (rng[1:0] != 2'b00);
      memory_step();
      // sample before the edge that makes the transfer.
      #1;
      if (dec_valid && dec_ready) check_item();
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/fetch_input.txt
# m <addr> <word>: memory image, hex
# w <ordinal> <addr> <word>, r <ordinal> <target>, f <ordinal> <target>; n <count>
n 36
m 80000000 00500093
m 80000004 12345137
m 80000008 00001197
m 8000000c fe112e23
m 80000010 00812203
m 80000014 004082b3
m 80000018 00000463
m 8000001c fff00313
m 80000020 fe009ce3
m 80000024 040000ef
m 80000028 00008067
m 8000002c 00000073
m 80000030 0000000f
m 80000034 7ff00393
m 80000038 00000013
m 8000003c 00000013
m 80000100 00100413
m 80000104 00140413
m 80000108 00000013
m 8000010c abcde4b7
m 80000110 fe0008e3
r 12 80000024
r 19 80000100
w 27 80000104 00240413
w 27 8000010c 00077517
f 27 80000104

// File: compile.f
+incdir+test
hdl/fetch_pkg.sv
hdl/fetch_if.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/fetch_top.sv
test/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
verilator --binary --timing --assert -f compile.f --top-module fetch_tb \
  -Mdir obj_dir -o fetch_sim > build.log 2>&1 || { echo "build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
